// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ULPI link testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ulpi_link_tb \
  -f sim.f \
  -Mdir obj_dir \
  -o ulpi_link_sim

./obj_dir/ulpi_link_sim | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
  echo "Run finished, pass message found in sim.log"
else
  echo "Pass message not found in sim.log"
  exit 1
fi

// ==== sim.f ====
source/ulpi_pkg.sv
source/ulpi_req_if.sv
source/ulpi_line_state.sv
source/ulpi_apb_regs.sv
source/ulpi_req_arbiter.sv
source/ulpi_tx_engine.sv
source/ulpi_link_top.sv
test/ulpi_link_assert.sv
test/ulpi_link_tb.sv

// ==== source/ulpi_apb_regs.sv ====
module ulpi_apb_regs (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [3:0]            paddr_i,
  input  logic [31:0]           pwdata_i,
  output logic [31:0]           prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  ulpi_req_if.requester         req_if,
  input  ulpi_pkg::line_state_e line_state_i,
  input  logic [1:0]            vbus_state_i,
  input  logic [1:0]            rx_event_i,
  input  logic                  high_speed_i,
  input  logic                  usb_reset_i
);
  import ulpi_pkg::*;

  typedef enum logic [1:0] {AP_IDLE, AP_REQ, AP_WAIT, AP_DONE} apb_state_e;

  apb_state_e state_q;
  logic       access;
  logic       phyw_wr;
  logic       mapped;
  logic [7:0] addr_q;
  logic [7:0] data_q;
  logic [7:0] status;

  assign access  = psel_i && penable_i;
  assign phyw_wr = access && pwrite_i && (paddr_i == APB_PHYW);
  assign mapped  = (paddr_i == APB_PHYW) || (paddr_i == APB_STATUS);

  // PHY write holds the APB access until the engine is done
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= AP_IDLE;
    end else begin
      case (state_q)
        AP_IDLE: if (phyw_wr) state_q <= AP_REQ;
        AP_REQ:  if (req_if.busy) state_q <= AP_WAIT;
        AP_WAIT: if (req_if.done) state_q <= AP_DONE;
        default: state_q <= AP_IDLE;  // AP_DONE, pready cycle
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == AP_IDLE && phyw_wr) begin
      addr_q <= TXCMD_REGW + {2'b00, pwdata_i[13:8]};
      data_q <= pwdata_i[7:0];
    end
  end

  assign req_if.req  = (state_q == AP_REQ);
  assign req_if.op   = OP_REG_WRITE;
  assign req_if.addr = addr_q;
  assign req_if.data = data_q;
  assign req_if.stop = 1'b0;

  // Everything but a PHY write finishes in its access cycle
  assign pready_o  = (state_q == AP_DONE) || (state_q == AP_IDLE && access && !phyw_wr);
  assign pslverr_o = (state_q == AP_IDLE) && access && !mapped;

  assign status = {usb_reset_i, high_speed_i, rx_event_i, vbus_state_i, line_state_i};

  assign prdata_o = (access && !pwrite_i && paddr_i == APB_STATUS) ? {24'h0, status} : 32'h0;

endmodule

// ==== source/ulpi_line_state.sv ====
module ulpi_line_state #(
  parameter bit                            HIGH_SPEED    = 1'b1,
  parameter logic [ulpi_pkg::TIMER_W-1:0] SUSPEND_TIME  = 18'd190000,  // ~3 ms
  parameter logic [ulpi_pkg::TIMER_W-1:0] RESET_TIME    = 18'd190000,  // ~3 ms
  parameter logic [ulpi_pkg::TIMER_W-1:0] CHIRP_K_TIME  = 18'd66000,   // ~1 ms
  parameter logic [ulpi_pkg::TIMER_W-1:0] CHIRP_KJ_TIME = 18'd120,     // ~2 us
  parameter logic [ulpi_pkg::TIMER_W-1:0] SWITCH_TIME   = 18'd6000     // ~100 us
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  ulpi_dir_i,
  input  logic                  ulpi_nxt_i,
  input  logic [7:0]            ulpi_data_i,
  ulpi_req_if.requester         req_if,
  output ulpi_pkg::line_state_e line_state_o,
  output logic [1:0]            vbus_state_o,
  output logic [1:0]            rx_event_o,
  output logic                  high_speed_o,
  output logic                  usb_reset_o
);
  import ulpi_pkg::*;

  link_state_e          state_q;
  link_state_e          next_q;     // Where to go once a write is done
  logic                 dir_q;
  logic [7:0]           dat_q;
  logic                 rx_cmd_q;
  line_state_e          line_state_q;
  logic [1:0]           vbus_q;
  logic [1:0]           rx_event_q;
  logic                 ls_changed;
  logic [TIMER_W-1:0]   st_count;
  logic [2:0]           kj_count;
  logic                 kj_done;
  logic                 hs_q;
  logic                 usb_rst_q;
  logic                 wr_go;
  logic [7:0]           wr_addr;
  logic [7:0]           wr_data;
  logic [7:0]           addr_q;
  logic [7:0]           data_q;

  // Input registers
  always_ff @(posedge clock) begin
    dir_q <= ulpi_dir_i;
    dat_q <= ulpi_data_i;
  end

  // RX CMD decode, skipping the turnaround cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      rx_cmd_q     <= 1'b0;
      line_state_q <= LS_SE0;
      vbus_q       <= 2'b00;
      rx_event_q   <= 2'b00;
    end else begin
      rx_cmd_q <= dir_q && ulpi_dir_i && !ulpi_nxt_i;
      if (rx_cmd_q) begin
        line_state_q <= line_state_e'(dat_q[1:0]);
        vbus_q       <= dat_q[3:2];
        rx_event_q   <= dat_q[5:4];
      end
    end
  end

  assign ls_changed = rx_cmd_q && (dat_q[1:0] != line_state_q);

  // Time since last line state change, and host KJ count
  always_ff @(posedge clock) begin
    if (reset || ls_changed || state_q == LX_CHIRP_STARTK || state_q == LX_SWITCH_FSSTART) begin
      st_count <= '0;
    end else if (st_count != '1) begin
      st_count <= st_count + 1'b1;
    end

    if (reset || state_q != LX_CHIRPKJ) begin
      kj_count <= 3'd0;
    end else if (ls_changed && dat_q[1:0] == LS_J && kj_count != 3'd7) begin
      kj_count <= kj_count + 3'd1;
    end
  end

  assign kj_done = (kj_count > 3'd3) && (st_count > CHIRP_KJ_TIME);

  // Which PHY register write a state starts
  always_comb begin
    wr_go   = 1'b0;
    wr_addr = REG_FUNC_CTRL;
    wr_data = FUNC_FS;
    case (state_q)
      LX_INIT: begin
        wr_go   = 1'b1;
        wr_addr = REG_OTG_CTRL;
        wr_data = 8'h00;
      end
      LX_SWITCH_FSSTART: wr_go = 1'b1;
      LX_CHIRP_START: begin
        wr_go   = 1'b1;
        wr_data = FUNC_CHIRP;
      end
      LX_CHIRPKJ: begin
        wr_go   = kj_done;
        wr_data = FUNC_HS;
      end
      default: wr_go = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (wr_go) begin
      addr_q <= wr_addr;
      data_q <= wr_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q   <= LX_INIT;
      next_q    <= LX_IDLE;
      hs_q      <= 1'b0;
      usb_rst_q <= 1'b0;
    end else begin
      if (wr_go) begin
        state_q <= LX_WRITE_REG;
      end
      case (state_q)
        LX_INIT:           next_q <= LX_SWITCH_FSSTART;
        LX_SWITCH_FSSTART: begin
          next_q <= LX_SWITCH_FS;
          hs_q   <= 1'b0;  // Back to full speed
        end
        LX_CHIRP_START:    next_q <= LX_CHIRP_STARTK;
        LX_CHIRPKJ: begin
          if (kj_done) begin
            next_q <= LX_IDLE;
            hs_q   <= 1'b1;
          end
        end
        LX_WRITE_REG:    if (req_if.busy) state_q <= LX_WAIT;
        LX_WAIT:         if (req_if.done) state_q <= next_q;
        LX_CHIRP_STARTK: if (req_if.busy) state_q <= LX_CHIRPK;
        LX_CHIRPK:       if (st_count > CHIRP_K_TIME) state_q <= LX_STOP;
        LX_STOP:         if (req_if.done) state_q <= LX_CHIRPKJ;
        LX_IDLE: begin
          usb_rst_q <= 1'b0;
          if (line_state_q == LS_SE0 && st_count > RESET_TIME) begin
            state_q <= LX_RESET;
          end else if (!hs_q && line_state_q == LS_J && st_count > SUSPEND_TIME) begin
            state_q <= LX_SUSPEND;
          end
        end
        LX_RESET: begin
          usb_rst_q <= 1'b1;
          if (HIGH_SPEED) begin
            state_q <= hs_q ? LX_SWITCH_FSSTART : LX_CHIRP_START;
          end else if (line_state_q != LS_SE0) begin
            state_q <= LX_IDLE;
          end
        end
        LX_SUSPEND: if (line_state_q != LS_J) state_q <= LX_IDLE;
        LX_SWITCH_FS: begin
          // Still SE0 after leaving HS means a bus reset
          if (st_count > SWITCH_TIME) begin
            if (usb_rst_q && HIGH_SPEED && line_state_q == LS_SE0) begin
              state_q <= LX_CHIRP_START;
            end else begin
              state_q <= LX_IDLE;
            end
          end
        end
        default: state_q <= LX_INIT;
      endcase
    end
  end

  assign req_if.req  = (state_q == LX_WRITE_REG) || (state_q == LX_CHIRP_STARTK);
  assign req_if.op   = (state_q == LX_CHIRP_STARTK) ? OP_NOPID : OP_REG_WRITE;
  assign req_if.addr = addr_q;
  assign req_if.data = data_q;
  assign req_if.stop = (state_q == LX_STOP);  // Ends the chirp K

  assign line_state_o = line_state_q;
  assign vbus_state_o = vbus_q;
  assign rx_event_o   = rx_event_q;
  assign high_speed_o = hs_q;
  assign usb_reset_o  = usb_rst_q;

endmodule

// ==== source/ulpi_link_top.sv ====
module ulpi_link_top #(
  parameter bit                            HIGH_SPEED    = 1'b1,
  parameter logic [ulpi_pkg::TIMER_W-1:0] SUSPEND_TIME  = 18'd190000,
  parameter logic [ulpi_pkg::TIMER_W-1:0] RESET_TIME    = 18'd190000,
  parameter logic [ulpi_pkg::TIMER_W-1:0] CHIRP_K_TIME  = 18'd66000,
  parameter logic [ulpi_pkg::TIMER_W-1:0] CHIRP_KJ_TIME = 18'd120,
  parameter logic [ulpi_pkg::TIMER_W-1:0] SWITCH_TIME   = 18'd6000
) (
  input  logic        clock,
  input  logic        reset,
  // ULPI
  input  logic        ulpi_dir_i,
  input  logic        ulpi_nxt_i,
  input  logic [7:0]  ulpi_data_i,
  output logic [7:0]  ulpi_data_o,
  output logic        ulpi_data_oe_o,
  output logic        ulpi_stp_o,
  // APB
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [3:0]  paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  output logic        high_speed_o,
  output logic        usb_reset_o
);
  import ulpi_pkg::*;

  line_state_e line_state;
  logic [1:0]  vbus_state;
  logic [1:0]  rx_event;

  ulpi_req_if ls_req_if ();
  ulpi_req_if apb_req_if ();
  ulpi_req_if phy_req_if ();

  ulpi_line_state #(
    .HIGH_SPEED    (HIGH_SPEED),
    .SUSPEND_TIME  (SUSPEND_TIME),
    .RESET_TIME    (RESET_TIME),
    .CHIRP_K_TIME  (CHIRP_K_TIME),
    .CHIRP_KJ_TIME (CHIRP_KJ_TIME),
    .SWITCH_TIME   (SWITCH_TIME)
  ) ulpi_line_state_inst (
    .clock        (clock),
    .reset        (reset),
    .ulpi_dir_i   (ulpi_dir_i),
    .ulpi_nxt_i   (ulpi_nxt_i),
    .ulpi_data_i  (ulpi_data_i),
    .req_if       (ls_req_if),
    .line_state_o (line_state),
    .vbus_state_o (vbus_state),
    .rx_event_o   (rx_event),
    .high_speed_o (high_speed_o),
    .usb_reset_o  (usb_reset_o)
  );

  ulpi_apb_regs ulpi_apb_regs_inst (
    .clock        (clock),
    .reset        (reset),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .req_if       (apb_req_if),
    .line_state_i (line_state),
    .vbus_state_i (vbus_state),
    .rx_event_i   (rx_event),
    .high_speed_i (high_speed_o),
    .usb_reset_i  (usb_reset_o)
  );

  // Line state wins over software writes
  ulpi_req_arbiter ulpi_req_arbiter_inst (
    .clock (clock),
    .reset (reset),
    .hi    (ls_req_if),
    .lo    (apb_req_if),
    .out   (phy_req_if)
  );

  ulpi_tx_engine ulpi_tx_engine_inst (
    .clock          (clock),
    .reset          (reset),
    .req_if         (phy_req_if),
    .ulpi_dir_i     (ulpi_dir_i),
    .ulpi_nxt_i     (ulpi_nxt_i),
    .ulpi_data_o    (ulpi_data_o),
    .ulpi_data_oe_o (ulpi_data_oe_o),
    .ulpi_stp_o     (ulpi_stp_o)
  );

endmodule

// ==== source/ulpi_pkg.sv ====
package ulpi_pkg;

  // UTMI line state as reported in RX CMD bits 1:0
  typedef enum logic [1:0] {
    LS_SE0 = 2'd0,
    LS_J   = 2'd1,
    LS_K   = 2'd2,
    LS_SE1 = 2'd3
  } line_state_e;

  // Attach, reset, suspend and chirp sequencer
  typedef enum logic [3:0] {
    LX_INIT           = 4'h0,
    LX_WRITE_REG      = 4'h1,
    LX_WAIT           = 4'h2,
    LX_RESET          = 4'h3,
    LX_SUSPEND        = 4'h4,
    LX_IDLE           = 4'h5,
    LX_STOP           = 4'h6,
    LX_CHIRP_START    = 4'h7,
    LX_CHIRP_STARTK   = 4'h8,
    LX_CHIRPK         = 4'h9,
    LX_CHIRPKJ        = 4'ha,
    LX_SWITCH_FSSTART = 4'hb,
    LX_SWITCH_FS      = 4'hc
  } link_state_e;

  // Operations the transmit engine can run
  typedef enum logic {
    OP_REG_WRITE = 1'b0,
    OP_NOPID     = 1'b1
  } ulpi_op_e;

  // TXCMD bytes
  localparam logic [7:0] TXCMD_REGW    = 8'h80;  // Register write, low six bits are the address
  localparam logic [7:0] REG_FUNC_CTRL = 8'h84;
  localparam logic [7:0] REG_OTG_CTRL  = 8'h8A;
  localparam logic [7:0] TXCMD_NOPID   = 8'h40;

  // Function control values
  localparam logic [7:0] FUNC_FS    = 8'h45;  // FS, normal op, suspendM
  localparam logic [7:0] FUNC_CHIRP = 8'h54;  // HS, chirp opmode
  localparam logic [7:0] FUNC_HS    = 8'h40;  // HS, normal op

  localparam int TIMER_W = 18;

  // APB register offsets
  localparam logic [3:0] APB_PHYW   = 4'h0;
  localparam logic [3:0] APB_STATUS = 4'h4;

endpackage

// ==== source/ulpi_req_arbiter.sv ====
module ulpi_req_arbiter (
  input  logic          clock,
  input  logic          reset,
  ulpi_req_if.engine    hi,    // Line state controller
  ulpi_req_if.engine    lo,    // APB registers
  ulpi_req_if.requester out
);

  logic gnt_valid_q;
  logic gnt_hi_q;

  // Grant is locked until the engine reports done
  always_ff @(posedge clock) begin
    if (reset) begin
      gnt_valid_q <= 1'b0;
      gnt_hi_q    <= 1'b0;
    end else if (!gnt_valid_q) begin
      if (hi.req) begin
        gnt_valid_q <= 1'b1;
        gnt_hi_q    <= 1'b1;
      end else if (lo.req) begin
        gnt_valid_q <= 1'b1;
        gnt_hi_q    <= 1'b0;
      end
    end else if (out.done) begin
      gnt_valid_q <= 1'b0;
    end
  end

  assign out.req  = gnt_valid_q && (gnt_hi_q ? hi.req : lo.req);
  assign out.op   = gnt_hi_q ? hi.op : lo.op;
  assign out.addr = gnt_hi_q ? hi.addr : lo.addr;
  assign out.data = gnt_hi_q ? hi.data : lo.data;
  assign out.stop = gnt_valid_q && (gnt_hi_q ? hi.stop : lo.stop);

  // Status only goes back to the owner
  assign hi.busy = gnt_valid_q && gnt_hi_q && out.busy;
  assign hi.done = gnt_valid_q && gnt_hi_q && out.done;
  assign lo.busy = gnt_valid_q && !gnt_hi_q && out.busy;
  assign lo.done = gnt_valid_q && !gnt_hi_q && out.done;

endmodule

// ==== source/ulpi_req_if.sv ====
interface ulpi_req_if;
  import ulpi_pkg::*;

  logic       req;
  ulpi_op_e   op;
  logic [7:0] addr;   // TXCMD byte for a register write
  logic [7:0] data;
  logic       busy;
  logic       done;   // One cycle, when STP goes out
  logic       stop;   // Ends a NOPID transmit

  modport requester (
    output req, op, addr, data, stop,
    input  busy, done
  );

  modport engine (
    input  req, op, addr, data, stop,
    output busy, done
  );

endinterface

// ==== source/ulpi_tx_engine.sv ====
module ulpi_tx_engine (
  input  logic       clock,
  input  logic       reset,
  ulpi_req_if.engine req_if,
  input  logic       ulpi_dir_i,
  input  logic       ulpi_nxt_i,
  output logic [7:0] ulpi_data_o,
  output logic       ulpi_data_oe_o,
  output logic       ulpi_stp_o
);
  import ulpi_pkg::*;

  typedef enum logic [2:0] {TX_IDLE, TX_CMD, TX_DATA, TX_HOLD, TX_STP} tx_state_e;

  tx_state_e  state_q;
  logic       dir_q;
  logic       drive_ok;
  ulpi_op_e   op_q;
  logic [7:0] addr_q;
  logic [7:0] data_q;

  // Bus is ours only after two low dir samples
  assign drive_ok = !ulpi_dir_i && !dir_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= TX_IDLE;
      dir_q   <= 1'b1;
    end else begin
      dir_q <= ulpi_dir_i;
      case (state_q)
        TX_IDLE: if (req_if.req) state_q <= TX_CMD;
        TX_CMD: begin
          if (drive_ok && ulpi_nxt_i) begin
            state_q <= (op_q == OP_NOPID) ? TX_HOLD : TX_DATA;
          end
        end
        TX_DATA: begin
          if (!drive_ok) begin
            state_q <= TX_CMD;  // PHY took the bus, start over
          end else if (ulpi_nxt_i) begin
            state_q <= TX_STP;
          end
        end
        TX_HOLD: begin
          if (!drive_ok) begin
            state_q <= TX_CMD;
          end else if (req_if.stop) begin
            state_q <= TX_STP;
          end
        end
        default: state_q <= drive_ok ? TX_IDLE : TX_CMD;  // TX_STP
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == TX_IDLE && req_if.req) begin
      op_q   <= req_if.op;
      addr_q <= req_if.addr;
      data_q <= req_if.data;
    end
  end

  always_comb begin
    case (state_q)
      TX_CMD:  ulpi_data_o = (op_q == OP_NOPID) ? TXCMD_NOPID : addr_q;
      TX_DATA: ulpi_data_o = data_q;
      default: ulpi_data_o = 8'h00;  // Idle, hold and STP drive zero
    endcase
  end

  assign ulpi_data_oe_o = drive_ok && (state_q != TX_IDLE);
  assign ulpi_stp_o     = drive_ok && (state_q == TX_STP);

  assign req_if.busy = (state_q != TX_IDLE);
  assign req_if.done = ulpi_stp_o;

endmodule

// ==== test/ulpi_link_assert.sv ====
module ulpi_link_assert (
  input logic                clock,
  input logic                reset,
  input logic                nxt_i,
  input logic [7:0]          bus_data_i,
  input logic                data_oe_i,
  input logic                stp_i,
  input logic                req_i,
  input ulpi_pkg::ulpi_op_e  op_i,
  input logic [7:0]          req_addr_i,
  input logic [7:0]          req_data_i,
  input logic                stop_i,
  input logic                busy_i
);

  // A byte stays on the bus until the PHY takes it with nxt
  byte_held_until_nxt: assert property (@(posedge clock) disable iff (reset)
    data_oe_i && !nxt_i && !stp_i |=> !data_oe_i || $stable(bus_data_i))
    else $error("ULPI byte changed before the PHY raised nxt");

  // STP only once the last byte was taken or the transmit was ended
  stp_after_last_byte: assert property (@(posedge clock) disable iff (reset)
    stp_i |-> $past(nxt_i) || $past(stop_i))
    else $error("ULPI STP before the PHY took the last byte");

  req_held_until_busy: assert property (@(posedge clock) disable iff (reset)
    req_i && !busy_i |=> req_i && $stable(op_i) && $stable(req_addr_i)
                         && $stable(req_data_i))
    else $error("Request dropped or changed before the engine went busy");

endmodule

bind ulpi_tx_engine ulpi_link_assert ulpi_link_assert_inst (
  .clock      (clock),
  .reset      (reset),
  .nxt_i      (ulpi_nxt_i),
  .bus_data_i (ulpi_data_o),
  .data_oe_i  (ulpi_data_oe_o),
  .stp_i      (ulpi_stp_o),
  .req_i      (req_if.req),
  .op_i       (req_if.op),
  .req_addr_i (req_if.addr),
  .req_data_i (req_if.data),
  .stop_i     (req_if.stop),
  .busy_i     (req_if.busy)
);

// ==== test/ulpi_link_tb.sv ====
module ulpi_link_tb;
  import ulpi_pkg::*;

  localparam int MAX_CYCLES = 20000;  // Whole run needs about 700 cycles

  logic        clock;
  logic        reset;
  logic        ulpi_dir;
  logic        ulpi_nxt;
  logic [7:0]  ulpi_rx_data;
  logic [7:0]  ulpi_tx_data;
  logic        ulpi_oe;
  logic        ulpi_stp;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        high_speed;
  logic        usb_reset;

  logic [7:0]  wr_addr_q[$];  // One entry per burst ended by STP
  logic [7:0]  wr_data_q[$];
  int          burst_len;
  logic [7:0]  burst_cmd;
  logic [7:0]  burst_dat;
  logic        nxt_next;
  int          abort_count;     // Bursts cut short by dir
  int          writes_at_ready;
  int          cycle_count;
  int          error_count;
  int          test_count;
  int          failed_tests;

  ulpi_link_top #(
    .HIGH_SPEED    (1'b1),
    .SUSPEND_TIME  (18'd100000),  // Never reached here
    .RESET_TIME    (18'd60),
    .CHIRP_K_TIME  (18'd20),
    .CHIRP_KJ_TIME (18'd4),
    .SWITCH_TIME   (18'd30)
  ) ulpi_link_top_inst (
    .clock          (clock),
    .reset          (reset),
    .ulpi_dir_i     (ulpi_dir),
    .ulpi_nxt_i     (ulpi_nxt),
    .ulpi_data_i    (ulpi_rx_data),
    .ulpi_data_o    (ulpi_tx_data),
    .ulpi_data_oe_o (ulpi_oe),
    .ulpi_stp_o     (ulpi_stp),
    .psel_i         (psel),
    .penable_i      (penable),
    .pwrite_i       (pwrite),
    .paddr_i        (paddr),
    .pwdata_i       (pwdata),
    .prdata_o       (prdata),
    .pready_o       (pready),
    .pslverr_o      (pslverr),
    .high_speed_o   (high_speed),
    .usb_reset_o    (usb_reset)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT never finished a test", cycle_count);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("FAIL %0t %s got %02h expected %02h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("FAIL %0t %s got %08h expected %08h", $time, name, got, exp);
    end
  endtask

  task automatic check_line(input string name, input line_state_e got, input line_state_e exp);
    if (got !== exp) begin
      error_count++;
      $display("FAIL %0t %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      error_count++;
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      error_count++;
      $display("At %0t expected %0d %s but saw %0d", $time, exp, what, got);
    end
  endtask

  task automatic check_write(input int idx, input logic [7:0] addr, input logic [7:0] data);
    if (idx >= wr_addr_q.size()) begin
      error_count++;
      $display("At %0t PHY write number %0d was never seen on the bus", $time, idx);
    end else begin
      check_byte($sformatf("wr_addr[%0d]", idx), wr_addr_q[idx], addr);
      check_byte($sformatf("wr_data[%0d]", idx), wr_data_q[idx], data);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("%s: ok", name);
    end else begin
      failed_tests++;
      $display("%s: %0d failed checks", name, error_count - errs_before);
    end
  endtask

  // PHY side, samples the bus at negedge and answers with nxt
  task automatic serve_phy_cycle();
    @(negedge clock);
    if (ulpi_oe && ulpi_stp) begin
      if (burst_len > 0 && burst_cmd == TXCMD_NOPID) begin
        wr_addr_q.push_back(TXCMD_NOPID);
        wr_data_q.push_back(8'h00);
      end else if (burst_len == 2) begin
        wr_addr_q.push_back(burst_cmd);
        wr_data_q.push_back(burst_dat);
      end
      burst_len = 0;
      nxt_next  = 1'b0;
    end else if (ulpi_oe) begin
      if (ulpi_nxt) begin  // Byte taken this cycle
        if (burst_len == 0) burst_cmd = ulpi_tx_data;
        if (burst_len == 1) burst_dat = ulpi_tx_data;
        burst_len++;
      end
      nxt_next = 1'b1;
    end else begin
      if (burst_len > 0) abort_count++;
      burst_len = 0;
      nxt_next  = 1'b0;
    end
    step();
    ulpi_nxt = nxt_next;
  endtask

  // Starts at once, so a caller can steal the bus mid-transfer
  task automatic send_rx_cmd(input logic [7:0] rx_cmd);
    ulpi_dir     = 1'b1;
    ulpi_rx_data = 8'h00;  // Turnaround
    step();
    ulpi_rx_data = rx_cmd;
    step();
    ulpi_dir     = 1'b0;
    ulpi_rx_data = 8'h00;
    step();
  endtask

  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    psel    = 1'b1;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    penable = 1'b0;
    step();
    penable = 1'b1;
    @(negedge clock);
    while (!pready) @(negedge clock);
    rdata           = prdata;
    err             = pslverr;
    writes_at_ready = wr_addr_q.size();
    step();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic test_init();
    int errs;
    errs = error_count;
    while (wr_addr_q.size() < 2) step();
    repeat (4) step();
    check_count("writes after reset", wr_addr_q.size(), 2);
    check_write(0, REG_OTG_CTRL, 8'h00);
    check_write(1, REG_FUNC_CTRL, FUNC_FS);
    check_bit("high_speed_o", high_speed, 1'b0);
    check_bit("usb_reset_o", usb_reset, 1'b0);
    send_rx_cmd(8'h0D);  // J, leaves SE0 before the reset timer runs out
    end_test("init", errs);
  endtask

  task automatic test_status();
    int          errs;
    logic [7:0]  rx_bytes[3];
    logic [31:0] rdata;
    logic        err;
    errs     = error_count;
    rx_bytes = '{8'h0D, 8'h1E, 8'h2D};  // Ends on J
    foreach (rx_bytes[i]) begin
      send_rx_cmd(rx_bytes[i]);
      apb_access(1'b0, APB_STATUS, 32'h0, rdata, err);
      check_word("prdata_o", rdata, {24'h0, 2'b00, rx_bytes[i][5:0]});
      check_line("status line state", line_state_e'(rdata[1:0]),
                 line_state_e'(rx_bytes[i][1:0]));
      check_bit("pslverr_o", err, 1'b0);
    end
    end_test("status", errs);
  endtask

  task automatic test_apb_write();
    int          errs;
    int          base;
    logic [31:0] rdata;
    logic        err;
    errs = error_count;
    base = wr_addr_q.size();
    apb_access(1'b1, APB_PHYW, 32'h0000_16A5, rdata, err);
    check_count("new PHY writes", wr_addr_q.size() - base, 1);
    check_write(base, 8'h96, 8'hA5);
    check_count("PHY writes seen by pready", writes_at_ready - base, 1);
    check_bit("pslverr_o", err, 1'b0);
    apb_access(1'b0, 4'h8, 32'h0, rdata, err);
    check_bit("pslverr_o", err, 1'b1);
    end_test("apb_write", errs);
  endtask

  task automatic test_dir_turnaround();
    int          errs;
    int          base;
    int          aborts;
    logic [31:0] rdata;
    logic        err;
    errs   = error_count;
    base   = wr_addr_q.size();
    aborts = abort_count;
    fork
      apb_access(1'b1, APB_PHYW, 32'h0000_11C3, rdata, err);
      begin
        while (!(ulpi_oe && ulpi_tx_data == 8'hC3)) step();
        send_rx_cmd(8'h0D);  // PHY grabs the bus on the data byte
      end
    join
    check_count("aborted bursts", abort_count - aborts, 1);
    check_count("new PHY writes", wr_addr_q.size() - base, 1);
    check_write(base, 8'h91, 8'hC3);
    end_test("dir_turnaround", errs);
  endtask

  task automatic test_reset_arbitration();
    int          errs;
    int          base;
    logic [31:0] rdata;
    logic        err;
    errs = error_count;
    base = wr_addr_q.size();
    send_rx_cmd(8'h0C);  // SE0
    while (!usb_reset) step();
    apb_access(1'b1, APB_PHYW, 32'h0000_055A, rdata, err);
    check_bit("usb_reset_o", usb_reset, 1'b1);
    check_count("new bursts", wr_addr_q.size() - base, 3);
    check_write(base, REG_FUNC_CTRL, FUNC_CHIRP);
    check_write(base + 1, TXCMD_NOPID, 8'h00);  // Chirp K ended by STP
    check_write(base + 2, 8'h85, 8'h5A);
    check_count("bursts seen by pready", writes_at_ready - base, 3);
    end_test("reset_arbitration", errs);
  endtask

  task automatic test_chirp_hs();
    int          errs;
    int          base;
    logic [31:0] rdata;
    logic        err;
    errs = error_count;
    base = wr_addr_q.size();
    repeat (4) begin
      send_rx_cmd(8'h0E);  // K
      send_rx_cmd(8'h0D);  // J
    end
    while (!high_speed) step();
    while (wr_addr_q.size() < base + 1 || usb_reset) step();
    check_write(base, REG_FUNC_CTRL, FUNC_HS);
    check_bit("high_speed_o", high_speed, 1'b1);
    apb_access(1'b0, APB_STATUS, 32'h0, rdata, err);
    check_word("prdata_o", rdata, 32'h0000_004D);
    check_line("status line state", line_state_e'(rdata[1:0]), LS_J);
    end_test("chirp_hs", errs);
  endtask

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    ulpi_dir     = 1'b0;
    ulpi_nxt     = 1'b0;
    ulpi_rx_data = 8'h00;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = 4'h0;
    pwdata       = 32'h0;
    burst_len    = 0;
    burst_cmd    = 8'h00;
    burst_dat    = 8'h00;
    nxt_next     = 1'b0;
    abort_count  = 0;
    cycle_count  = 0;
    error_count  = 0;
    test_count   = 0;
    failed_tests = 0;
    fork
      forever serve_phy_cycle();
    join_none
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;
    test_init();
    test_status();
    test_apb_write();
    test_dir_turnaround();
    test_reset_arbitration();
    test_chirp_hs();
    $display("Tests: %0d, failed tests: %0d, failed checks: %0d",
             test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
